// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - files:
      - hw/rv_core_pkg.sv
      - hw/rv_fetch_unit.sv
      - hw/rv_decoder.sv
      - hw/rv_register_file.sv
      - hw/rv_execute_unit.sv
      - hw/rv_retire_unit.sv
      - hw/rv_core_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_rv_core.sv

// ==== bench/tb_rv_program.svh ====
localparam int PROG_LEN = 19;

logic [31:0] prog_addr [PROG_LEN];
logic [31:0] prog_inst [PROG_LEN];
logic [4:0]  prog_rd   [PROG_LEN];
logic [31:0] prog_data [PROG_LEN];

task automatic set_row(input int idx, input logic [31:0] addr, input logic [31:0] inst,
                       input logic [4:0] rd, input logic [31:0] data);
  prog_addr[idx] = addr;
  prog_inst[idx] = inst;
  prog_rd[idx]   = rd;
  prog_data[idx] = data;
endtask

// Rows in execution order
// Columns are row, fetch address, instruction word, expected rd, expected data
task automatic load_program_table();
  set_row(0,  32'h8000_0000, 32'h0050_0093, 5'd1,  32'h0000_0005);  // addi x1, x0, 5
  set_row(1,  32'h8000_0004, 32'hffd0_0113, 5'd2,  32'hffff_fffd);  // addi x2, x0, -3
  set_row(2,  32'h8000_0008, 32'h0020_81b3, 5'd3,  32'h0000_0002);  // add  x3, x1, x2
  set_row(3,  32'h8000_000c, 32'h4020_8233, 5'd4,  32'h0000_0008);  // sub  x4, x1, x2
  set_row(4,  32'h8000_0010, 32'h0020_f2b3, 5'd5,  32'h0000_0005);  // and  x5, x1, x2
  set_row(5,  32'h8000_0014, 32'h0020_e333, 5'd6,  32'hffff_fffd);  // or   x6, x1, x2
  set_row(6,  32'h8000_0018, 32'h0020_c3b3, 5'd7,  32'hffff_fff8);  // xor  x7, x1, x2
  set_row(7,  32'h8000_001c, 32'h0011_2433, 5'd8,  32'h0000_0001);  // slt  x8, x2, x1
  set_row(8,  32'h8000_0020, 32'h0020_a4b3, 5'd9,  32'h0000_0000);  // slt  x9, x1, x2
  set_row(9,  32'h8000_0024, 32'h1234_5537, 5'd10, 32'h1234_5000);  // lui  x10, 0x12345
  set_row(10, 32'h8000_0028, 32'h0000_1597, 5'd11, 32'h8000_1028);  // auipc x11, 0x1
  set_row(11, 32'h8000_002c, 32'h0070_8013, 5'd0,  32'h0000_0000);  // addi x0, x1, 7
  set_row(12, 32'h8000_0030, 32'h0010_0633, 5'd12, 32'h0000_0005);  // add  x12, x0, x1
  set_row(13, 32'h8000_0034, 32'h0050_8463, 5'd0,  32'h0000_0000);  // beq  x1, x5, +8
  set_row(14, 32'h8000_003c, 32'h0050_9863, 5'd0,  32'h0000_0000);  // bne  x1, x5, +16
  set_row(15, 32'h8000_0040, 32'h00c0_06ef, 5'd13, 32'h8000_0044);  // jal  x13, +12
  set_row(16, 32'h8000_004c, 32'h0106_8767, 5'd14, 32'h8000_0050);  // jalr x14, 16(x13)
  set_row(17, 32'h8000_0054, 32'h00e6_87b3, 5'd15, 32'h0000_0094);  // add  x15, x13, x14
  set_row(18, 32'h8000_0058, 32'h0010_0073, 5'd0,  32'h0000_0000);  // ebreak
endtask

// ==== bench/tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core;

  localparam logic [31:0] RESET_PC       = 32'h8000_0000;
  localparam int          IMEM_WORDS     = 64;
  localparam int          SETUP_TIMEOUT  = 20;
  localparam int          COMMIT_TIMEOUT = 40;
  localparam int          HALT_WATCH     = 20;
  localparam logic [31:0] RAND_SEED      = 32'hec8b7784;

  logic        clk;
  logic        rst;
  logic [31:0] paddr_o;
  logic        psel_o;
  logic        penable_o;
  logic [31:0] prdata_i;
  logic        pready_i;
  logic        commit_valid_o;
  logic [31:0] commit_pc_o;
  logic [4:0]  commit_rd_o;
  logic [31:0] commit_data_o;
  logic        halted_o;

  logic [31:0] imem [IMEM_WORDS];
  int unsigned wait_draw;
  int unsigned wait_left;

  // APB protocol monitor state
  logic        psel_seen;
  logic [31:0] paddr_seen;
  logic        done_d1;
  logic        done_d2;

  `include "tb_rv_program.svh"

  rv_core_top #(
    .RESET_PC (RESET_PC)
  ) i_dut (
    .clk            (clk),
    .rst            (rst),
    .paddr_o        (paddr_o),
    .psel_o         (psel_o),
    .penable_o      (penable_o),
    .prdata_i       (prdata_i),
    .pready_i       (pready_i),
    .commit_valid_o (commit_valid_o),
    .commit_pc_o    (commit_pc_o),
    .commit_rd_o    (commit_rd_o),
    .commit_data_o  (commit_data_o),
    .halted_o       (halted_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic abort_run();
    $display("TEST FAIL");
    $fatal(1, "simulation stopped after a failure");
  endtask

  task automatic check_value(input string what, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("error at %0t ns: %s got %h, expected %h", $time, what, actual, expected);
      abort_run();
    end
  endtask

  // Unused words get a pattern built from the whole address
  function automatic logic [31:0] fill_pattern(input logic [31:0] addr);
    return {addr[15:0], addr[31:16]} ^ 32'h3c5a_96e1;
  endfunction

  function automatic logic [31:0] read_imem(input logic [31:0] addr);
    logic [31:0] offset;
    offset = addr - RESET_PC;
    if ((offset < IMEM_WORDS * 4) && (addr[1:0] == 2'b00)) begin
      return imem[offset >> 2];
    end
    return fill_pattern(addr);
  endfunction

  task automatic fill_memory();
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = fill_pattern(RESET_PC + 4 * i);
    end
    for (int row = 0; row < PROG_LEN; row++) begin
      imem[(prog_addr[row] - RESET_PC) >> 2] = prog_inst[row];
    end
  endtask

  task automatic wait_for_commit(input int row);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!commit_valid_o) begin
      if (cycles >= COMMIT_TIMEOUT) begin
        $display("timeout: commit of row %0d at pc %h never arrived", row, prog_addr[row]);
        abort_run();
      end
      cycles++;
      @(negedge clk);
    end
  endtask

  // APB completer drawing 0 to 3 wait states in the setup cycle
  initial begin
    int unsigned seed_ret;
    seed_ret = $urandom(RAND_SEED);
    forever begin
      @(posedge clk);
      if (rst) begin
        pready_i  <= 1'b0;
        prdata_i  <= '0;
        wait_left <= 0;
      end else if (psel_o && !penable_o) begin
        wait_draw = $urandom % 4;
        wait_left <= wait_draw;
        if (wait_draw == 0) begin
          pready_i <= 1'b1;
          prdata_i <= read_imem(paddr_o);
        end
      end else if (psel_o && penable_o) begin
        if (pready_i) begin
          // Transfer completes on this edge
          pready_i <= 1'b0;
          prdata_i <= '0;
        end else if (wait_left == 1) begin
          pready_i  <= 1'b1;
          prdata_i  <= read_imem(paddr_o);
          wait_left <= 0;
        end else begin
          wait_left <= wait_left - 1;
        end
      end
    end
  end

  // Address stability and commit latency sampled mid-cycle
  always @(negedge clk) begin
    if (rst) begin
      psel_seen = 1'b0;
      done_d1   = 1'b0;
      done_d2   = 1'b0;
    end else begin
      if (psel_seen && psel_o) begin
        check_value("paddr_o during transfer", paddr_o, paddr_seen);
      end
      check_value("commit_valid_o vs APB completion", commit_valid_o, done_d2);
      done_d2    = done_d1;
      done_d1    = psel_o && penable_o && pready_i;
      psel_seen  = psel_o;
      paddr_seen = paddr_o;
    end
  end

  initial begin
    int cycles;
    rst       = 1'b1;
    prdata_i  = '0;
    pready_i  = 1'b0;
    load_program_table();
    fill_memory();

    @(posedge clk);
    @(negedge clk);
    check_value("psel_o in reset", psel_o, 1'b0);
    check_value("penable_o in reset", penable_o, 1'b0);
    check_value("commit_valid_o in reset", commit_valid_o, 1'b0);
    check_value("halted_o in reset", halted_o, 1'b0);
    @(posedge clk);
    @(posedge clk);
    rst <= 1'b0;

    // First setup cycle fetches from the reset vector
    cycles = 0;
    @(negedge clk);
    while (!psel_o) begin
      if (cycles >= SETUP_TIMEOUT) begin
        $display("timeout: no APB setup cycle after reset release");
        abort_run();
      end
      cycles++;
      @(negedge clk);
    end
    check_value("penable_o in first setup", penable_o, 1'b0);
    check_value("paddr_o in first setup", paddr_o, RESET_PC);

    for (int row = 0; row < PROG_LEN; row++) begin
      wait_for_commit(row);
      check_value($sformatf("row %0d commit_pc_o", row), commit_pc_o, prog_addr[row]);
      check_value($sformatf("row %0d commit_rd_o", row), commit_rd_o, prog_rd[row]);
      check_value($sformatf("row %0d commit_data_o", row), commit_data_o, prog_data[row]);
      check_value($sformatf("row %0d halted_o", row), halted_o, (row == PROG_LEN - 1));
    end

    // Core stays parked after EBREAK
    repeat (HALT_WATCH) begin
      @(negedge clk);
      check_value("psel_o after halt", psel_o, 1'b0);
      check_value("halted_o after halt", halted_o, 1'b1);
    end

    $display("TEST PASS");
    $finish;
  end

endmodule

// ==== hw/rv_core_pkg.sv ====
package rv_core_pkg;

  // Machine word width
  localparam int XLEN = 32;

  // Reset vector unless the top level overrides it
  localparam logic [XLEN-1:0] DEFAULT_RESET_PC = 32'h8000_0000;

  // Major opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    SYSTEM = 7'b1110011
  } opcode_e;

  // Operations of the ALU
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    // Forward operand B untouched, used by LUI
    ALU_PASS_B
  } alu_op_e;

  // funct3 encodings shared by OP and OP_IMM
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;

  // funct12 of EBREAK within SYSTEM
  localparam logic [11:0] F12_EBREAK = 12'h001;

endpackage

// ==== hw/rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top #(
  parameter logic [rv_core_pkg::XLEN-1:0] RESET_PC = rv_core_pkg::DEFAULT_RESET_PC
) (
  input  logic                         clk,
  input  logic                         rst,
  output logic [rv_core_pkg::XLEN-1:0] paddr_o,
  output logic                         psel_o,
  output logic                         penable_o,
  input  logic [31:0]                  prdata_i,
  input  logic                         pready_i,
  output logic                         commit_valid_o,
  output logic [rv_core_pkg::XLEN-1:0] commit_pc_o,
  output logic [4:0]                   commit_rd_o,
  output logic [rv_core_pkg::XLEN-1:0] commit_data_o,
  output logic                         halted_o
);

  import rv_core_pkg::*;

  // Fetch
  logic            inst_valid;
  logic [31:0]     inst;

  // Decode
  logic [4:0]      rs1;
  logic [4:0]      rs2;
  logic [4:0]      rd;
  logic [XLEN-1:0] imm;
  opcode_e         opcode;
  alu_op_e         alu_op;
  logic            reg_write;
  logic            ebreak;

  // Register file, execute and retire
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  logic [XLEN-1:0] result;
  logic [XLEN-1:0] next_pc;
  logic [XLEN-1:0] pc;
  logic            retire_pulse;

  rv_fetch_unit u_fetch (
    .clk          (clk),
    .rst          (rst),
    .pc_i         (pc),
    .retire_i     (retire_pulse),
    .halted_i     (halted_o),
    .paddr_o      (paddr_o),
    .psel_o       (psel_o),
    .penable_o    (penable_o),
    .prdata_i     (prdata_i),
    .pready_i     (pready_i),
    .inst_valid_o (inst_valid),
    .inst_o       (inst)
  );

  rv_decoder u_decoder (
    .inst_i      (inst),
    .rs1_o       (rs1),
    .rs2_o       (rs2),
    .rd_o        (rd),
    .imm_o       (imm),
    .opcode_o    (opcode),
    .alu_op_o    (alu_op),
    .reg_write_o (reg_write),
    .ebreak_o    (ebreak)
  );

  // Write only in the single cycle the instruction is valid
  rv_register_file u_regfile (
    .clk      (clk),
    .rst      (rst),
    .we_i     (reg_write & inst_valid),
    .waddr_i  (rd),
    .raddr1_i (rs1),
    .raddr2_i (rs2),
    .wdata_i  (result),
    .rdata1_o (rs1_data),
    .rdata2_o (rs2_data)
  );

  rv_execute_unit u_execute (
    .pc_i          (pc),
    .opcode_i      (opcode),
    .alu_op_i      (alu_op),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .imm_i         (imm),
    .funct3_bit0_i (inst[12]),
    .result_o      (result),
    .next_pc_o     (next_pc)
  );

  rv_retire_unit #(
    .RESET_PC (RESET_PC)
  ) u_retire (
    .clk            (clk),
    .rst            (rst),
    .inst_valid_i   (inst_valid),
    .next_pc_i      (next_pc),
    .result_i       (result),
    .rd_i           (rd),
    .ebreak_i       (ebreak),
    .pc_o           (pc),
    .retire_o       (retire_pulse),
    .commit_valid_o (commit_valid_o),
    .commit_pc_o    (commit_pc_o),
    .commit_rd_o    (commit_rd_o),
    .commit_data_o  (commit_data_o),
    .halted_o       (halted_o)
  );

endmodule

// ==== hw/rv_decoder.sv ====
`timescale 1ns/1ps

module rv_decoder (
  input  logic [31:0]                  inst_i,
  output logic [4:0]                   rs1_o,
  output logic [4:0]                   rs2_o,
  output logic [4:0]                   rd_o,
  output logic [rv_core_pkg::XLEN-1:0] imm_o,
  output rv_core_pkg::opcode_e         opcode_o,
  output rv_core_pkg::alu_op_e         alu_op_o,
  output logic                         reg_write_o,
  output logic                         ebreak_o
);

  import rv_core_pkg::*;

  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i_type;
  logic [XLEN-1:0] imm_u_type;
  logic [XLEN-1:0] imm_j_type;
  logic [XLEN-1:0] imm_b_type;

  assign funct3   = inst_i[14:12];
  assign funct7   = inst_i[31:25];
  assign opcode_o = opcode_e'(inst_i[6:0]);

  assign rs1_o = inst_i[19:15];
  assign rs2_o = inst_i[24:20];

  // RV32I immediate formats, sign taken from bit 31
  assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_u_type = {inst_i[31:12], 12'b0};
  assign imm_j_type = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
  assign imm_b_type = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};

  always_comb begin
    imm_o       = '0;
    alu_op_o    = ALU_ADD;
    reg_write_o = 1'b0;
    ebreak_o    = 1'b0;
    case (opcode_o)
      OP: begin
        reg_write_o = 1'b1;
        case (funct3)
          F3_ADD:  alu_op_o = funct7[5] ? ALU_SUB : ALU_ADD;
          F3_SLT:  alu_op_o = ALU_SLT;
          F3_XOR:  alu_op_o = ALU_XOR;
          F3_OR:   alu_op_o = ALU_OR;
          F3_AND:  alu_op_o = ALU_AND;
          default: alu_op_o = ALU_ADD;
        endcase
      end
      OP_IMM: begin
        reg_write_o = 1'b1;
        imm_o       = imm_i_type;
        // No subtract form for immediates
        case (funct3)
          F3_SLT:  alu_op_o = ALU_SLT;
          F3_XOR:  alu_op_o = ALU_XOR;
          F3_OR:   alu_op_o = ALU_OR;
          F3_AND:  alu_op_o = ALU_AND;
          default: alu_op_o = ALU_ADD;
        endcase
      end
      LUI: begin
        reg_write_o = 1'b1;
        imm_o       = imm_u_type;
        alu_op_o    = ALU_PASS_B;
      end
      AUIPC: begin
        reg_write_o = 1'b1;
        imm_o       = imm_u_type;
      end
      JAL: begin
        reg_write_o = 1'b1;
        imm_o       = imm_j_type;
      end
      JALR: begin
        reg_write_o = 1'b1;
        imm_o       = imm_i_type;
      end
      BRANCH: begin
        // Equality comes from a zero difference
        imm_o    = imm_b_type;
        alu_op_o = ALU_SUB;
      end
      SYSTEM: begin
        ebreak_o = (inst_i[31:20] == F12_EBREAK);
      end
      default: begin
        alu_op_o = ALU_ADD;
      end
    endcase
  end

  // No destination reported when nothing is written
  assign rd_o = reg_write_o ? inst_i[11:7] : 5'd0;

endmodule

// ==== hw/rv_execute_unit.sv ====
`timescale 1ns/1ps

module rv_execute_unit (
  input  logic [rv_core_pkg::XLEN-1:0] pc_i,
  input  rv_core_pkg::opcode_e         opcode_i,
  input  rv_core_pkg::alu_op_e         alu_op_i,
  input  logic [rv_core_pkg::XLEN-1:0] rs1_data_i,
  input  logic [rv_core_pkg::XLEN-1:0] rs2_data_i,
  input  logic [rv_core_pkg::XLEN-1:0] imm_i,
  input  logic                         funct3_bit0_i,
  output logic [rv_core_pkg::XLEN-1:0] result_o,
  output logic [rv_core_pkg::XLEN-1:0] next_pc_o
);

  import rv_core_pkg::*;

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] alu_out;
  logic [XLEN-1:0] pc_plus4;
  logic [XLEN-1:0] jalr_target;
  logic            branch_taken;

  // Operand selection
  assign op_a = (opcode_i == AUIPC) ? pc_i : rs1_data_i;
  assign op_b = ((opcode_i == OP) || (opcode_i == BRANCH)) ? rs2_data_i : imm_i;

  always_comb begin
    case (alu_op_i)
      ALU_ADD:    alu_out = op_a + op_b;
      ALU_SUB:    alu_out = op_a - op_b;
      ALU_AND:    alu_out = op_a & op_b;
      ALU_OR:     alu_out = op_a | op_b;
      ALU_XOR:    alu_out = op_a ^ op_b;
      ALU_SLT:    alu_out = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_PASS_B: alu_out = op_b;
      default:    alu_out = op_a + op_b;
    endcase
  end

  // BEQ when funct3 bit 0 is clear, BNE when set
  assign branch_taken = (alu_out == '0) ^ funct3_bit0_i;

  assign pc_plus4    = pc_i + 32'd4;
  assign jalr_target = (rs1_data_i + imm_i) & ~32'd1;

  // Jumps write the link address
  assign result_o = ((opcode_i == JAL) || (opcode_i == JALR)) ? pc_plus4 : alu_out;

  always_comb begin
    case (opcode_i)
      JAL:     next_pc_o = pc_i + imm_i;
      JALR:    next_pc_o = jalr_target;
      BRANCH:  next_pc_o = branch_taken ? pc_i + imm_i : pc_plus4;
      // EBREAK parks the pc on itself
      SYSTEM:  next_pc_o = pc_i;
      default: next_pc_o = pc_plus4;
    endcase
  end

endmodule

// ==== hw/rv_fetch_unit.sv ====
`timescale 1ns/1ps

module rv_fetch_unit (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [rv_core_pkg::XLEN-1:0] pc_i,
  input  logic                         retire_i,
  input  logic                         halted_i,
  output logic [rv_core_pkg::XLEN-1:0] paddr_o,
  output logic                         psel_o,
  output logic                         penable_o,
  input  logic [31:0]                  prdata_i,
  input  logic                         pready_i,
  output logic                         inst_valid_o,
  output logic [31:0]                  inst_o
);

  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS,
    WAIT_RETIRE
  } fetch_state_e;

  fetch_state_e state_q;
  fetch_state_e state_d;
  logic         access_done;

  // Completing edge of the APB transfer
  assign access_done = (state_q == ACCESS) && pready_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (!halted_i) begin
          state_d = SETUP;
        end
      end
      SETUP: begin
        state_d = ACCESS;
      end
      ACCESS: begin
        // Wait states just hold here
        if (pready_i) begin
          state_d = WAIT_RETIRE;
        end
      end
      WAIT_RETIRE: begin
        if (retire_i) begin
          state_d = halted_i ? IDLE : SETUP;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q      <= IDLE;
      inst_valid_o <= 1'b0;
    end else begin
      state_q      <= state_d;
      inst_valid_o <= access_done;
    end
  end

  always_ff @(posedge clk) begin
    if (access_done) begin
      inst_o <= prdata_i;
    end
  end

  // PC only moves at retire, so the address is stable over the transfer
  assign paddr_o   = pc_i;
  assign psel_o    = (state_q == SETUP) || (state_q == ACCESS);
  assign penable_o = (state_q == ACCESS);

endmodule

// ==== hw/rv_register_file.sv ====
`timescale 1ns/1ps

module rv_register_file (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         we_i,
  input  logic [4:0]                   waddr_i,
  input  logic [4:0]                   raddr1_i,
  input  logic [4:0]                   raddr2_i,
  input  logic [rv_core_pkg::XLEN-1:0] wdata_i,
  output logic [rv_core_pkg::XLEN-1:0] rdata1_o,
  output logic [rv_core_pkg::XLEN-1:0] rdata2_o
);

  import rv_core_pkg::*;

  logic [XLEN-1:0] regs_q [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != 5'd0)) begin
      // x0 never gets written and stays zero
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata1_o = regs_q[raddr1_i];
  assign rdata2_o = regs_q[raddr2_i];

endmodule

// ==== hw/rv_retire_unit.sv ====
`timescale 1ns/1ps

module rv_retire_unit #(
  parameter logic [rv_core_pkg::XLEN-1:0] RESET_PC = rv_core_pkg::DEFAULT_RESET_PC
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         inst_valid_i,
  input  logic [rv_core_pkg::XLEN-1:0] next_pc_i,
  input  logic [rv_core_pkg::XLEN-1:0] result_i,
  input  logic [4:0]                   rd_i,
  input  logic                         ebreak_i,
  output logic [rv_core_pkg::XLEN-1:0] pc_o,
  output logic                         retire_o,
  output logic                         commit_valid_o,
  output logic [rv_core_pkg::XLEN-1:0] commit_pc_o,
  output logic [4:0]                   commit_rd_o,
  output logic [rv_core_pkg::XLEN-1:0] commit_data_o,
  output logic                         halted_o
);

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_o           <= RESET_PC;
      commit_valid_o <= 1'b0;
      halted_o       <= 1'b0;
    end else begin
      commit_valid_o <= inst_valid_i;
      if (inst_valid_i) begin
        pc_o <= next_pc_i;
      end
      // Sticky until the next reset
      if (inst_valid_i && ebreak_i) begin
        halted_o <= 1'b1;
      end
    end
  end

  // Commit record carries the pc before the update
  always_ff @(posedge clk) begin
    if (inst_valid_i) begin
      commit_pc_o   <= pc_o;
      commit_rd_o   <= rd_i;
      commit_data_o <= (rd_i != 5'd0) ? result_i : '0;
    end
  end

  // Fetch restarts once the commit is out
  assign retire_o = commit_valid_o;

endmodule

// ==== vlog.f ====
+incdir+bench
hw/rv_core_pkg.sv
hw/rv_fetch_unit.sv
hw/rv_decoder.sv
hw/rv_register_file.sv
hw/rv_execute_unit.sv
hw/rv_retire_unit.sv
hw/rv_core_top.sv
bench/tb_rv_core.sv
